// File: src/stream_defines.svh
// stream accumulator widths and depths

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// beat payload
`define STREAM_DATA_W 32
`define STREAM_STRB_W 4

// beat counter inside the accumulator
`define STREAM_CNT_W 16

// fifo depths, at least 3 for the early stall
`define STREAM_IN_DEPTH 8
`define STREAM_OUT_DEPTH 4

`endif

// File: src/stream_pkg.sv
// stream accumulator types

`include "stream_defines.svh"

package stream_pkg;

  // one input beat, last marks the end of a packet
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] data;
    logic [`STREAM_STRB_W-1:0] strb;
    logic                      last;
  } beat_t;

  // one result per packet
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] sum;
    logic [`STREAM_CNT_W-1:0]  count;
  } result_t;

  // fifo status
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

endpackage

// File: src/stream_fifo_earlystall.sv
// early-stall stream FIFO
// circular buffer with a generic payload

`timescale 1ns/1ps

module stream_fifo_earlystall #(
  parameter type         payload_t = stream_pkg::beat_t,
  parameter int unsigned DEPTH     = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    push_valid_i,
  output logic                    push_ready_o,
  input  payload_t                push_data_i,
  output logic                    pop_valid_o,
  input  logic                    pop_ready_i,
  output payload_t                pop_data_o,
  output stream_pkg::fifo_flags_t flags_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR    = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_LEVEL  = CNT_W'(DEPTH);
  // ready drops two slots before full
  localparam logic [CNT_W-1:0] STALL_LEVEL = CNT_W'(DEPTH - 2);

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } state_e;

  state_e           state_q, state_d;
  logic [PTR_W-1:0] push_ptr_q, push_ptr_d, push_ptr_inc;
  logic [PTR_W-1:0] pop_ptr_q, pop_ptr_d, pop_ptr_inc;
  logic [CNT_W-1:0] fill_cnt;
  logic             push_en;
  logic             pop_en;
  payload_t         mem_q [DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a push lands whenever there is room, ready is only the early warning
  assign push_en     = push_valid_i && (state_q != FULL);
  assign pop_valid_o = (state_q != EMPTY);
  assign pop_en      = pop_valid_o && pop_ready_i;

  assign flags_o.empty = (state_q == EMPTY);
  assign flags_o.full  = (state_q == FULL);

  // pointers wrap at the last slot
  assign push_ptr_inc = (push_ptr_q == LAST_PTR) ? '0 : push_ptr_q + 1'b1;
  assign pop_ptr_inc  = (pop_ptr_q == LAST_PTR) ? '0 : pop_ptr_q + 1'b1;

  // occupancy from the pointer distance
  always_comb begin
    case (state_q)
      EMPTY: begin
        fill_cnt = '0;
      end
      FULL: begin
        fill_cnt = FULL_LEVEL;
      end
      default: begin
        if (push_ptr_q > pop_ptr_q) begin
          fill_cnt = CNT_W'(push_ptr_q - pop_ptr_q);
        end else begin
          fill_cnt = FULL_LEVEL - CNT_W'(pop_ptr_q - push_ptr_q);
        end
      end
    endcase
  end

  assign push_ready_o = (fill_cnt < STALL_LEVEL);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fsm
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d    = state_q;
    push_ptr_d = push_en ? push_ptr_inc : push_ptr_q;
    pop_ptr_d  = pop_en ? pop_ptr_inc : pop_ptr_q;

    case (state_q)
      EMPTY: begin
        if (push_en) begin
          state_d = (push_ptr_inc == pop_ptr_q) ? FULL : MIDDLE;
        end
      end
      MIDDLE: begin
        case ({push_en, pop_en})
          2'b10: begin
            // push only, may catch up with the read side
            if (push_ptr_inc == pop_ptr_q) begin
              state_d = FULL;
            end
          end
          2'b01: begin
            // pop only, may drain the last entry
            if (pop_ptr_inc == push_ptr_q) begin
              state_d = EMPTY;
            end
          end
          default: begin
            state_d = MIDDLE;
          end
        endcase
      end
      FULL: begin
        if (pop_en) begin
          state_d = (pop_ptr_inc == push_ptr_q) ? EMPTY : MIDDLE;
        end
      end
      default: begin
        state_d    = EMPTY;
        push_ptr_d = '0;
        pop_ptr_d  = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      state_q    <= state_d;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (push_en) begin
      mem_q[push_ptr_q] <= push_data_i;
    end
  end

  // head of the queue, zero while nothing is queued
  assign pop_data_o = pop_valid_o ? mem_q[pop_ptr_q] : '0;

endmodule

// File: src/stream_beat_accum.sv
// packet byte accumulator

`timescale 1ns/1ps

`include "stream_defines.svh"

module stream_beat_accum (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                beat_valid_i,
  output logic                beat_ready_o,
  input  stream_pkg::beat_t   beat_i,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output stream_pkg::result_t res_o
);

  localparam int unsigned DATA_W = `STREAM_DATA_W;
  localparam int unsigned STRB_W = `STREAM_STRB_W;
  localparam int unsigned CNT_W  = `STREAM_CNT_W;
  localparam int unsigned BYTE_W = DATA_W / STRB_W;

  logic [DATA_W-1:0]   sum_q, sum_d;
  logic [DATA_W-1:0]   beat_bytes;
  logic [CNT_W-1:0]    cnt_q, cnt_d;
  logic                res_valid_q;
  stream_pkg::result_t res_q;
  logic                beat_fire;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one beat per cycle while the result slot is free
  assign beat_ready_o = ~res_valid_q;
  assign beat_fire    = beat_valid_i && beat_ready_o;

  // strobe-masked byte sum of the current beat
  always_comb begin
    beat_bytes = '0;
    for (int unsigned b = 0; b < STRB_W; b++) begin
      if (beat_i.strb[b]) begin
        beat_bytes = beat_bytes + DATA_W'(beat_i.data[b*BYTE_W +: BYTE_W]);
      end
    end
  end

  // running totals including this beat, sum wraps mod 2^32
  assign sum_d = sum_q + beat_bytes;
  assign cnt_d = cnt_q + 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // accumulator and result control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else if (clear_i) begin
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (res_valid_q && res_ready_i) begin
        res_valid_q <= 1'b0;
      end
      if (beat_fire) begin
        if (beat_i.last) begin
          // packet done, restart for the next one
          sum_q       <= '0;
          cnt_q       <= '0;
          res_valid_q <= 1'b1;
        end else begin
          sum_q <= sum_d;
          cnt_q <= cnt_d;
        end
      end
    end
  end

  // result payload, loaded with the totals of the last beat
  always_ff @(posedge clk_i) begin
    if (beat_fire && beat_i.last) begin
      res_q.sum   <= sum_d;
      res_q.count <= cnt_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // held until the output fifo takes it
  assign res_valid_o = res_valid_q;
  assign res_o       = res_valid_q ? res_q : '0;

endmodule

// File: src/stream_accum_top.sv
// stream accumulator top level

`timescale 1ns/1ps

`include "stream_defines.svh"

module stream_accum_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    beat_valid_i,
  output logic                    beat_ready_o,
  input  stream_pkg::beat_t       beat_i,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output stream_pkg::result_t     result_o,
  output stream_pkg::fifo_flags_t in_flags_o
);

  logic                    acc_beat_valid;
  logic                    acc_beat_ready;
  stream_pkg::beat_t       acc_beat;
  logic                    acc_res_valid;
  logic                    acc_res_ready;
  stream_pkg::result_t     acc_res;
  stream_pkg::fifo_flags_t out_flags;

  // the output fifo lands a push whenever it is not full,
  // so the held result is taken on the first such cycle
  assign acc_res_ready = ~out_flags.full;

  stream_fifo_earlystall #(
    .payload_t ( stream_pkg::beat_t ),
    .DEPTH     ( `STREAM_IN_DEPTH   )
  ) i_in_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( beat_valid_i   ),
    .push_ready_o ( beat_ready_o   ),
    .push_data_i  ( beat_i         ),
    .pop_valid_o  ( acc_beat_valid ),
    .pop_ready_i  ( acc_beat_ready ),
    .pop_data_o   ( acc_beat       ),
    .flags_o      ( in_flags_o     )
  );

  stream_beat_accum i_accum (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .beat_valid_i ( acc_beat_valid ),
    .beat_ready_o ( acc_beat_ready ),
    .beat_i       ( acc_beat       ),
    .res_valid_o  ( acc_res_valid  ),
    .res_ready_i  ( acc_res_ready  ),
    .res_o        ( acc_res        )
  );

  // one result in flight at a time, so the early stall is not needed here
  stream_fifo_earlystall #(
    .payload_t ( stream_pkg::result_t ),
    .DEPTH     ( `STREAM_OUT_DEPTH    )
  ) i_out_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( acc_res_valid  ),
    .push_ready_o (                ),
    .push_data_i  ( acc_res        ),
    .pop_valid_o  ( result_valid_o ),
    .pop_ready_i  ( result_ready_i ),
    .pop_data_o   ( result_o       ),
    .flags_o      ( out_flags      )
  );

endmodule

// File: bench/stream_accum_props.sv
// stream accumulator handshake checks

`timescale 1ns/1ps

module stream_accum_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    clear_i,
  input logic                    in_push_valid_i,
  input stream_pkg::fifo_flags_t in_flags_i,
  input logic                    mid_valid_i,
  input logic                    mid_ready_i,
  input stream_pkg::beat_t       mid_beat_i,
  input logic                    acc_valid_i,
  input stream_pkg::result_t     acc_res_i,
  input stream_pkg::fifo_flags_t out_flags_i,
  input logic                    res_valid_i,
  input logic                    res_ready_i,
  input stream_pkg::result_t     res_i
);

  // number of failed assertions so far
  int unsigned err_cnt = 0;

  // input fifo head holds while the accumulator stalls
  in_pop_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mid_valid_i && !mid_ready_i && !clear_i |=> $stable(mid_beat_i))
    else begin
      $error("input fifo head changed while stalled");
      err_cnt++;
    end

  // output fifo head holds while the consumer stalls
  out_pop_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i && !res_ready_i && !clear_i |=> $stable(res_i))
    else begin
      $error("output fifo head changed while stalled");
      err_cnt++;
    end

  // no beat offered to a full input fifo
  in_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_push_valid_i && in_flags_i.full))
    else begin
      $error("push into full input fifo");
      err_cnt++;
    end

  // a result facing a full output fifo is held unchanged
  acc_hold_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_valid_i && out_flags_i.full && !clear_i |=> acc_valid_i && $stable(acc_res_i))
    else begin
      $error("held result dropped or changed");
      err_cnt++;
    end

  reset_no_valid: assert property (@(posedge clk_i)
    !rst_ni |-> !res_valid_i && !mid_valid_i && !acc_valid_i)
    else begin
      $error("valid asserted during reset");
      err_cnt++;
    end

endmodule

bind stream_accum_top stream_accum_props i_props (
  .clk_i           ( clk_i          ),
  .rst_ni          ( rst_ni         ),
  .clear_i         ( clear_i        ),
  .in_push_valid_i ( beat_valid_i   ),
  .in_flags_i      ( in_flags_o     ),
  .mid_valid_i     ( acc_beat_valid ),
  .mid_ready_i     ( acc_beat_ready ),
  .mid_beat_i      ( acc_beat       ),
  .acc_valid_i     ( acc_res_valid  ),
  .acc_res_i       ( acc_res        ),
  .out_flags_i     ( out_flags      ),
  .res_valid_i     ( result_valid_o ),
  .res_ready_i     ( result_ready_i ),
  .res_i           ( result_o       )
);

// File: bench/tb_stream_accum.sv
// stream accumulator testbench

`timescale 1ns/1ps

`include "stream_defines.svh"

module tb_stream_accum;

  localparam int unsigned CLK_PERIOD  = 8;
  localparam logic [31:0] SEED        = 32'hd805_18e0;
  localparam int unsigned N_SINGLE    = 8;
  localparam int unsigned N_MULTI     = 12;
  localparam int unsigned N_BP        = 30;
  localparam int unsigned MAX_BEATS   = N_SINGLE + N_MULTI * 6 + N_BP * 8 + 24;
  localparam int unsigned WATCHDOG_NS = (MAX_BEATS * 16 + 400) * CLK_PERIOD;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    clear_i;
  logic                    beat_valid_i;
  logic                    beat_ready_o;
  stream_pkg::beat_t       beat_i;
  logic                    result_valid_o;
  logic                    result_ready_i;
  stream_pkg::result_t     result_o;
  stream_pkg::fifo_flags_t in_flags_o;

  logic [31:0]         rng_state;
  logic [31:0]         rdy_state;
  logic                rand_ready;
  stream_pkg::result_t exp_q [$];

  stream_accum_top uut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // reference sum of the zero-extended bytes with their strobe set, mod 2^32
  function automatic logic [31:0] masked_sum(input logic [31:0] d, input logic [3:0] s);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        acc = acc + ((d >> (8 * i)) & 32'h0000_00ff);
      end
    end
    return acc;
  endfunction

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  // valid is dropped while waiting so a stalled beat is never pushed twice
  task automatic send_beat(input stream_pkg::beat_t b, input bit obey_ready);
    while (obey_ready && !beat_ready_o) begin
      beat_valid_i = 1'b0;
      @(negedge clk_i);
    end
    beat_valid_i = 1'b1;
    beat_i       = b;
    @(negedge clk_i);
  endtask

  task automatic stop_beats();
    beat_valid_i = 1'b0;
    beat_i       = '0;
  endtask

  task automatic send_packet(input int unsigned n, input bit full_strb, input bit obey_ready);
    stream_pkg::beat_t   beats [$];
    stream_pkg::beat_t   b;
    stream_pkg::result_t expected;
    logic [31:0]         r;
    expected = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r      = next_random();
      b.data = next_random();
      b.strb = full_strb ? 4'hf : r[3:0];
      b.last = (i == n - 1);
      expected.sum = expected.sum + masked_sum(b.data, b.strb);
      beats.push_back(b);
    end
    expected.count = n[`STREAM_CNT_W-1:0];
    exp_q.push_back(expected);
    foreach (beats[i]) begin
      send_beat(beats[i], obey_ready);
    end
    stop_beats();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic check_quiet_outputs();
    check_value("in_flags_o.empty", in_flags_o.empty, 1);
    check_value("in_flags_o.full", in_flags_o.full, 0);
    check_value("result_valid_o", result_valid_o, 0);
    check_value("result_o", result_o, 0);
    check_value("beat_ready_o", beat_ready_o, 1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor and ready driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk_i) begin
    stream_pkg::result_t expected;
    if (rst_ni && result_valid_o && result_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t ns: a result came out with none expected", $time);
        stop_with_failure();
      end else begin
        expected = exp_q.pop_front();
        check_value("result_o.sum", result_o.sum, expected.sum);
        check_value("result_o.count", result_o.count, expected.count);
      end
    end
  end

  always @(uut.i_props.err_cnt) begin
    if (uut.i_props.err_cnt != 0) begin
      $display("ERROR at %0t ns: a handshake assertion failed", $time);
      stop_with_failure();
    end
  end

  always @(negedge clk_i) begin
    if (rand_ready) begin
      rdy_state      = xorshift(rdy_state);
      result_ready_i = rdy_state[7];
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired, the DUT stopped making progress");
    stop_with_failure();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic single_beat_test();
    repeat (N_SINGLE) send_packet(1, 1'b1, 1'b1);
    wait_drain();
  endtask

  task automatic multi_beat_test();
    repeat (N_MULTI) send_packet(2 + next_random() % 5, 1'b0, 1'b1);
    wait_drain();
  endtask

  task automatic early_stall_test();
    int unsigned accepted;
    result_ready_i = 1'b0;
    // four results fill the output fifo and the fifth waits in the accumulator
    repeat (5) send_packet(1, 1'b1, 1'b1);
    while (!in_flags_o.empty) @(negedge clk_i);
    accepted = 0;
    while (beat_ready_o) begin
      send_packet(1, 1'b1, 1'b1);
      accepted++;
    end
    check_value("beats accepted before stall", accepted, `STREAM_IN_DEPTH - 2);
    check_value("in_flags_o.full", in_flags_o.full, 0);
    // the two slack slots still take beats
    repeat (2) send_packet(1, 1'b1, 1'b0);
    check_value("in_flags_o.full", in_flags_o.full, 1);
    check_value("beat_ready_o", beat_ready_o, 0);
    result_ready_i = 1'b1;
    wait_drain();
  endtask

  task automatic backpressure_test();
    rand_ready = 1'b1;
    repeat (N_BP) send_packet(1 + next_random() % 8, 1'b0, 1'b1);
    rand_ready = 1'b0;
    @(negedge clk_i);
    result_ready_i = 1'b1;
    wait_drain();
  endtask

  task automatic clear_test();
    stream_pkg::beat_t b;
    // a stale result waits in the output fifo while a packet is half done
    result_ready_i = 1'b0;
    b = '{data: next_random(), strb: 4'hf, last: 1'b1};
    send_beat(b, 1'b1);
    repeat (3) begin
      b = '{data: next_random(), strb: 4'hf, last: 1'b0};
      send_beat(b, 1'b1);
    end
    // clear lands while a further beat is offered
    b       = '{data: next_random(), strb: 4'hf, last: 1'b0};
    beat_i  = b;
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    stop_beats();
    check_quiet_outputs();
    result_ready_i = 1'b1;
    send_packet(3, 1'b0, 1'b1);
    wait_drain();
  endtask

  task automatic idle_test();
    repeat (20) begin
      @(negedge clk_i);
      check_value("result_valid_o", result_valid_o, 0);
      check_value("result_o", result_o, 0);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    beat_valid_i   = 1'b0;
    beat_i         = '0;
    result_ready_i = 1'b1;
    rand_ready     = 1'b0;
    rng_state      = SEED;
    rdy_state      = ~SEED;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_quiet_outputs();

    single_beat_test();
    multi_beat_test();
    early_stall_test();
    backpressure_test();
    clear_test();
    idle_test();

    if (exp_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("ERROR: %0d expected results never came out", exp_q.size());
      stop_with_failure();
    end
  end

endmodule

// File: src.f
+incdir+src
src/stream_pkg.sv
src/stream_fifo_earlystall.sv
src/stream_beat_accum.sv
src/stream_accum_top.sv
bench/stream_accum_props.sv
bench/tb_stream_accum.sv

// File: Bender.yml
package:
  name: stream_accum

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/stream_pkg.sv
      - src/stream_fifo_earlystall.sv
      - src/stream_beat_accum.sv
      - src/stream_accum_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/stream_accum_props.sv
      - bench/tb_stream_accum.sv
